/* hw/rob_cfg_pkg.sv */
package rob_cfg_pkg;

	// instruction address, one full word
	localparam int pc_width = 64;

	// architectural register number
	localparam int arn_width = 5;

	// physical register file
	localparam int prf_size = 64;
	localparam int prn_width = $clog2(prf_size);

	// entries per thread bank
	// index arithmetic wraps, so keep this a power of two
	localparam int default_rob_depth = 16;

endpackage

/* hw/rob_types_pkg.sv */
package rob_types_pkg;

	// top bit of every tag
	typedef enum logic
	{
		thread_1 = 1'b0,
		thread_2 = 1'b1
	} thread_id_t;

	// one instruction from dispatch
	typedef struct packed
	{
		logic valid;
		logic [rob_cfg_pkg::pc_width-1:0] pc;
		logic [rob_cfg_pkg::arn_width-1:0] arn_dest;
		logic [rob_cfg_pkg::prn_width-1:0] prn_dest;
		logic is_branch;
	} dispatch_slot_t;

	// one result from a function unit, the tag goes alongside
	typedef struct packed
	{
		logic valid;
		logic mispredict;
		logic [rob_cfg_pkg::pc_width-1:0] target_pc;
	} complete_t;

	// one retiring instruction, also used for the bank head views
	typedef struct packed
	{
		logic valid;
		thread_id_t thread;
		logic [rob_cfg_pkg::pc_width-1:0] pc;
		logic [rob_cfg_pkg::pc_width-1:0] target_pc;
		logic [rob_cfg_pkg::arn_width-1:0] arn_dest;
		logic [rob_cfg_pkg::prn_width-1:0] prn_dest;
		logic is_branch;
		logic mispredict;
	} commit_slot_t;

endpackage

/* hw/rob_thread_bank.sv */
module rob_thread_bank #(
	parameter int rob_depth = rob_cfg_pkg::default_rob_depth,
	parameter rob_types_pkg::thread_id_t bank_thread = rob_types_pkg::thread_1
) (
	input logic clock,
	input logic reset,
	input logic is_thread1,
	input rob_types_pkg::dispatch_slot_t slot1,
	input rob_types_pkg::dispatch_slot_t slot2,
	input rob_types_pkg::complete_t fu1,
	input rob_types_pkg::complete_t fu2,
	input logic [$clog2(rob_depth)-1:0] fu1_index,
	input logic [$clog2(rob_depth)-1:0] fu2_index,
	input logic [1:0] pop,
	input logic flush,
	output logic [$clog2(rob_depth)-1:0] tail_index,
	output logic [$clog2(rob_depth)-1:0] next_index,
	output logic full,
	output rob_types_pkg::commit_slot_t head0,
	output rob_types_pkg::commit_slot_t head1
);
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	localparam int idx_width = $clog2(rob_depth);
	localparam int cnt_width = idx_width + 1;

	// entry storage, one array per field
	logic [pc_width-1:0] pc_mem [rob_depth];
	logic [pc_width-1:0] target_mem [rob_depth];
	logic [arn_width-1:0] arn_mem [rob_depth];
	logic [prn_width-1:0] prn_mem [rob_depth];
	logic [rob_depth-1:0] branch_mem;
	logic [rob_depth-1:0] mispredict_mem;
	logic [rob_depth-1:0] executed;

	logic [idx_width-1:0] head;
	logic [idx_width-1:0] head_plus1;
	logic [idx_width-1:0] head_next;
	logic [idx_width-1:0] tail;
	logic [cnt_width-1:0] count;
	logic selected;
	logic dispatch_en;
	logic [cnt_width-1:0] dispatch_num;

	function automatic commit_slot_t entry_view(input logic [idx_width-1:0] idx,
			input logic occupied);
		commit_slot_t view;
		view.valid = occupied && executed[idx];
		view.thread = bank_thread;
		view.pc = pc_mem[idx];
		view.target_pc = target_mem[idx];
		view.arn_dest = arn_mem[idx];
		view.prn_dest = prn_mem[idx];
		view.is_branch = branch_mem[idx];
		view.mispredict = mispredict_mem[idx]; // raw, the arbiter masks it
		return view;
	endfunction

	assign selected = (bank_thread == thread_1) ? is_thread1 : !is_thread1;
	assign full = (count > cnt_width'(rob_depth - 2)); // fewer than two free
	assign dispatch_en = selected && slot1.valid && !full && !flush;
	assign dispatch_num = !dispatch_en ? '0 : (slot2.valid ? cnt_width'(2) : cnt_width'(1));

	assign tail_index = tail;
	assign next_index = tail + 1'b1;
	assign head_plus1 = head + 1'b1;
	assign head_next = head + idx_width'(pop);

	assign head0 = entry_view(head, count != '0);
	assign head1 = entry_view(head_plus1, count > cnt_width'(1));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			head <= head_next;
			if (flush)
			begin
				// drop everything younger than the committed branch
				tail <= head_next;
				count <= '0;
			end
			else
			begin
				tail <= tail + idx_width'(dispatch_num);
				count <= count - cnt_width'(pop) + dispatch_num;
			end
		end
	end

	// payload fields
	always_ff @(posedge clock)
	begin
		if (dispatch_en)
		begin
			pc_mem[tail] <= slot1.pc;
			arn_mem[tail] <= slot1.arn_dest;
			prn_mem[tail] <= slot1.prn_dest;
			branch_mem[tail] <= slot1.is_branch;
			if (slot2.valid)
			begin
				pc_mem[next_index] <= slot2.pc;
				arn_mem[next_index] <= slot2.arn_dest;
				prn_mem[next_index] <= slot2.prn_dest;
				branch_mem[next_index] <= slot2.is_branch;
			end
		end
		if (fu1.valid)
		begin
			target_mem[fu1_index] <= fu1.target_pc;
			mispredict_mem[fu1_index] <= fu1.mispredict;
		end
		if (fu2.valid)
		begin
			target_mem[fu2_index] <= fu2.target_pc;
			mispredict_mem[fu2_index] <= fu2.mispredict;
		end
	end

	// executed flags, a fresh dispatch clears its entry
	always_ff @(posedge clock)
	begin
		if (reset)
			executed <= '0;
		else
		begin
			if (fu1.valid)
				executed[fu1_index] <= 1'b1;
			if (fu2.valid)
				executed[fu2_index] <= 1'b1;
			if (dispatch_en)
			begin
				executed[tail] <= 1'b0;
				if (slot2.valid)
					executed[next_index] <= 1'b0;
			end
		end
	end

endmodule

/* hw/rob_commit_arbiter.sv */
module rob_commit_arbiter #(
	parameter int rob_depth = rob_cfg_pkg::default_rob_depth
) (
	input rob_types_pkg::commit_slot_t t1_head0,
	input rob_types_pkg::commit_slot_t t1_head1,
	input rob_types_pkg::commit_slot_t t2_head0,
	input rob_types_pkg::commit_slot_t t2_head1,
	output rob_types_pkg::commit_slot_t commit1,
	output rob_types_pkg::commit_slot_t commit2,
	output logic [1:0] t1_pop,
	output logic [1:0] t2_pop,
	output logic t1_flush,
	output logic t2_flush
);
	import rob_types_pkg::*;

	commit_slot_t grant1;
	commit_slot_t grant2;
	commit_slot_t second;
	logic kill1;
	logic kill2;

	always_comb
	begin
		grant1 = '0;
		grant2 = '0;

		// slot1 prefers thread 1
		if (t1_head0.valid)
			grant1 = t1_head0;
		else if (t2_head0.valid)
			grant1 = t2_head0;

		kill1 = grant1.valid && grant1.is_branch && grant1.mispredict;

		// slot2 from the same thread unless slot1 flushes it
		second = (grant1.thread == thread_1) ? t1_head1 : t2_head1;
		if (grant1.valid && !kill1 && second.valid)
			grant2 = second;

		// otherwise the thread-2 head may fill in behind thread 1
		if (!grant2.valid && grant1.valid && grant1.thread == thread_1 && t2_head0.valid)
			grant2 = t2_head0;

		kill2 = grant2.valid && grant2.is_branch && grant2.mispredict;
	end

	always_comb
	begin
		t1_pop = 2'(grant1.valid && grant1.thread == thread_1)
			+ 2'(grant2.valid && grant2.thread == thread_1);
		t2_pop = 2'(grant1.valid && grant1.thread == thread_2)
			+ 2'(grant2.valid && grant2.thread == thread_2);

		t1_flush = (kill1 && grant1.thread == thread_1) || (kill2 && grant2.thread == thread_1);
		t2_flush = (kill1 && grant1.thread == thread_2) || (kill2 && grant2.thread == thread_2);
	end

	always_comb
	begin
		commit1 = grant1;
		commit2 = grant2;
		commit1.mispredict = kill1; // only branches report a mispredict
		commit2.mispredict = kill2;
	end

endmodule

/* hw/smt_rob.sv */
module smt_rob #(
	parameter int rob_depth = rob_cfg_pkg::default_rob_depth
) (
	input logic clock,
	input logic reset,
	input logic is_thread1,
	input rob_types_pkg::dispatch_slot_t slot1,
	input rob_types_pkg::dispatch_slot_t slot2,
	input rob_types_pkg::complete_t fu1,
	input rob_types_pkg::complete_t fu2,
	input logic [$clog2(rob_depth):0] fu1_tag,
	input logic [$clog2(rob_depth):0] fu2_tag,
	output logic [$clog2(rob_depth):0] tag1,
	output logic [$clog2(rob_depth):0] tag2,
	output rob_types_pkg::commit_slot_t commit1,
	output rob_types_pkg::commit_slot_t commit2,
	output logic t1_full,
	output logic t2_full
);
	import rob_types_pkg::*;

	localparam int idx_width = $clog2(rob_depth);

	complete_t t1_fu1;
	complete_t t1_fu2;
	complete_t t2_fu1;
	complete_t t2_fu2;
	logic [idx_width-1:0] t1_tail;
	logic [idx_width-1:0] t1_next;
	logic [idx_width-1:0] t2_tail;
	logic [idx_width-1:0] t2_next;
	commit_slot_t t1_head0;
	commit_slot_t t1_head1;
	commit_slot_t t2_head0;
	commit_slot_t t2_head1;
	logic [1:0] t1_pop;
	logic [1:0] t2_pop;
	logic t1_flush;
	logic t2_flush;

	// completions go only to the bank named by the tag
	always_comb
	begin
		t1_fu1 = fu1;
		t2_fu1 = fu1;
		t1_fu2 = fu2;
		t2_fu2 = fu2;
		t1_fu1.valid = fu1.valid && (thread_id_t'(fu1_tag[idx_width]) == thread_1);
		t2_fu1.valid = fu1.valid && (thread_id_t'(fu1_tag[idx_width]) == thread_2);
		t1_fu2.valid = fu2.valid && (thread_id_t'(fu2_tag[idx_width]) == thread_1);
		t2_fu2.valid = fu2.valid && (thread_id_t'(fu2_tag[idx_width]) == thread_2);
	end

	assign tag1 = is_thread1 ? {thread_1, t1_tail} : {thread_2, t2_tail};
	assign tag2 = is_thread1 ? {thread_1, t1_next} : {thread_2, t2_next};

	rob_thread_bank #(.rob_depth(rob_depth), .bank_thread(thread_1)) u_bank_t1 (
		.clock(clock), .reset(reset), .is_thread1(is_thread1),
		.slot1(slot1), .slot2(slot2), .fu1(t1_fu1), .fu2(t1_fu2),
		.fu1_index(fu1_tag[idx_width-1:0]), .fu2_index(fu2_tag[idx_width-1:0]),
		.pop(t1_pop), .flush(t1_flush), .tail_index(t1_tail), .next_index(t1_next),
		.full(t1_full), .head0(t1_head0), .head1(t1_head1)
	);

	rob_thread_bank #(.rob_depth(rob_depth), .bank_thread(thread_2)) u_bank_t2 (
		.clock(clock), .reset(reset), .is_thread1(is_thread1),
		.slot1(slot1), .slot2(slot2), .fu1(t2_fu1), .fu2(t2_fu2),
		.fu1_index(fu1_tag[idx_width-1:0]), .fu2_index(fu2_tag[idx_width-1:0]),
		.pop(t2_pop), .flush(t2_flush), .tail_index(t2_tail), .next_index(t2_next),
		.full(t2_full), .head0(t2_head0), .head1(t2_head1)
	);

	rob_commit_arbiter #(.rob_depth(rob_depth)) u_arbiter (
		.t1_head0(t1_head0), .t1_head1(t1_head1), .t2_head0(t2_head0), .t2_head1(t2_head1),
		.commit1(commit1), .commit2(commit2), .t1_pop(t1_pop), .t2_pop(t2_pop),
		.t1_flush(t1_flush), .t2_flush(t2_flush)
	);

endmodule

/* test/tb_smt_rob.sv */
module tb_smt_rob;
	timeunit 1ns;
	timeprecision 1ps;
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	localparam int depth = default_rob_depth;
	localparam int iw = $clog2(depth);

	// one in-flight instruction of the model
	typedef struct packed
	{
		logic [iw-1:0] idx;
		logic executed;
		logic mispredict;
		logic [pc_width-1:0] target_pc;
		dispatch_slot_t slot;
	} model_entry_t;

	logic clock = 1'b0;
	logic reset;
	logic is_thread1;
	dispatch_slot_t slot1;
	dispatch_slot_t slot2;
	complete_t fu1;
	complete_t fu2;
	logic [iw:0] fu1_tag;
	logic [iw:0] fu2_tag;
	logic [iw:0] tag1;
	logic [iw:0] tag2;
	commit_slot_t commit1;
	commit_slot_t commit2;
	logic t1_full;
	logic t2_full;

	model_entry_t mq [2][$]; // index 0 is thread 1
	logic [iw-1:0] head [2] = '{default: '0};
	logic [iw-1:0] tail [2] = '{default: '0};
	logic [31:0] rng = 32'hca9c_8252;
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int dual_seen = 0;
	int flush_seen = 0;
	bit timed_out = 1'b0;

	smt_rob #(.rob_depth(depth)) u_dut (.*);

	always #20 clock = ~clock;

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	function automatic dispatch_slot_t random_slot(input bit valid);
		dispatch_slot_t s;
		logic [31:0] r;
		r = next_random();
		s.valid = valid;
		s.pc = {next_random(), next_random()};
		s.arn_dest = r[arn_width-1:0];
		s.prn_dest = r[prn_width+7:8];
		s.is_branch = (r[18:16] < 3'd3); // a few branches
		return s;
	endfunction

	function automatic bit ready(input int t, input int k);
		return mq[t].size() > k && mq[t][k].executed;
	endfunction

	function automatic commit_slot_t as_commit(input int t, input model_entry_t e);
		commit_slot_t c;
		c.valid = 1'b1;
		c.thread = thread_id_t'(t[0]);
		c.pc = e.slot.pc;
		c.target_pc = e.target_pc;
		c.arn_dest = e.slot.arn_dest;
		c.prn_dest = e.slot.prn_dest;
		c.is_branch = e.slot.is_branch;
		c.mispredict = e.slot.is_branch && e.mispredict;
		return c;
	endfunction

	// commit rule applied to the model queues
	task automatic expect_commits(output commit_slot_t c1, output commit_slot_t c2);
		int t;
		c1 = '0;
		c2 = '0;
		t = ready(0, 0) ? 0 : 1;
		if (ready(t, 0))
			c1 = as_commit(t, mq[t][0]);
		if (c1.valid && !c1.mispredict && ready(t, 1))
			c2 = as_commit(t, mq[t][1]);
		if (!c2.valid && c1.valid && t == 0 && ready(1, 0))
			c2 = as_commit(1, mq[1][0]); // thread 2 fills in behind thread 1
	endtask

	task automatic report_error(input string msg);
		errors++;
		test_errors++;
		$display("%s", msg);
	endtask

	task automatic check_value(input string what, input logic [255:0] got,
			input logic [255:0] exp);
		checks++;
		if (got !== exp)
			report_error($sformatf("[FAIL] time %0d ns: %s is %0h, expected %0h",
				$time, what, got, exp));
	endtask

	// one clock cycle of stimulus, checks and model update
	task automatic step(input bit disp, input bit thr1, input bit two, input int ncomp,
			input bit free_run);
		commit_slot_t cs [2];
		complete_t comp [2];
		logic [iw:0] ctag [2];
		int ct [2];
		int cj [2];
		int cand_t [$];
		int cand_j [$];
		bit flush [2];
		model_entry_t e;
		logic [31:0] r;
		int t;
		int pick;
		bit accept;
		@(negedge clock);
		expect_commits(cs[0], cs[1]);
		check_value("commit1", 256'(commit1), 256'(cs[0]));
		check_value("commit2", 256'(commit2), 256'(cs[1]));
		check_value("t1_full", 256'(t1_full), 256'(mq[0].size() > depth - 2));
		check_value("t2_full", 256'(t2_full), 256'(mq[1].size() > depth - 2));
		if (cs[0].valid && cs[1].valid && cs[0].thread == thread_1 && cs[1].thread == thread_1)
			dual_seen++;
		if (cs[0].mispredict || cs[1].mispredict)
			flush_seen++;
		t = thr1 ? 0 : 1;
		if (free_run && (thr1 ? t1_full : t2_full))
			disp = 1'b0; // random traffic stays off a full thread
		is_thread1 = thr1;
		slot1 = random_slot(disp);
		slot2 = random_slot(disp && two);
		for (int k = 0; k < 2; k++)
			for (int j = 0; j < mq[k].size(); j++)
				if (!mq[k][j].executed)
				begin
					cand_t.push_back(k);
					cand_j.push_back(j);
				end
		comp[0] = '0;
		comp[1] = '0;
		ctag[0] = '0;
		ctag[1] = '0;
		for (int n = 0; n < 2 && n < ncomp && cand_t.size() > 0; n++)
		begin
			r = next_random();
			pick = int'(r % 32'(cand_t.size()));
			ct[n] = cand_t[pick];
			cj[n] = cand_j[pick];
			cand_t.delete(pick);
			cand_j.delete(pick);
			comp[n].valid = 1'b1;
			comp[n].mispredict = free_run && r[9:8] == 2'd0;
			comp[n].target_pc = {next_random(), next_random()};
			ctag[n] = {ct[n][0], mq[ct[n]][cj[n]].idx};
		end
		fu1 = comp[0];
		fu2 = comp[1];
		fu1_tag = ctag[0];
		fu2_tag = ctag[1];
		#1;
		check_value("tag1", 256'(tag1), 256'({t[0], tail[t]}));
		check_value("tag2", 256'(tag2), 256'({t[0], tail[t] + 1'b1}));
		@(posedge clock);
		accept = slot1.valid && mq[t].size() <= depth - 2; // full before this edge
		for (int n = 0; n < 2; n++)
			if (comp[n].valid)
			begin
				e = mq[ct[n]][cj[n]];
				e.executed = 1'b1;
				e.mispredict = comp[n].mispredict;
				e.target_pc = comp[n].target_pc;
				mq[ct[n]][cj[n]] = e;
			end
		flush[0] = 1'b0;
		flush[1] = 1'b0;
		for (int n = 0; n < 2; n++)
			if (cs[n].valid)
			begin
				pick = int'(cs[n].thread);
				void'(mq[pick].pop_front());
				head[pick] = head[pick] + 1'b1;
				if (cs[n].mispredict)
					flush[pick] = 1'b1;
			end
		for (int k = 0; k < 2; k++)
			if (flush[k])
			begin
				mq[k].delete();
				tail[k] = head[k]; // new tags restart at the head
			end
		if (accept && !flush[t])
			for (int n = 0; n < 2; n++)
				if (n == 0 || slot2.valid)
				begin
					e = '0;
					e.idx = tail[t];
					e.slot = (n == 0) ? slot1 : slot2;
					mq[t].push_back(e);
					tail[t] = tail[t] + 1'b1;
				end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %s, %0d errors", name, test_errors == 0 ? "passed" : "failed",
			test_errors);
		test_errors = 0;
	endtask

	task automatic drain(input int limit);
		int cycles;
		cycles = 0;
		while ((mq[0].size() != 0 || mq[1].size() != 0) && cycles < limit)
		begin
			step(1'b0, 1'b1, 1'b0, 2, 1'b0);
			cycles++;
		end
		if (mq[0].size() != 0 || mq[1].size() != 0)
		begin
			$display("timeout: the ROB did not drain within %0d cycles", limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_tests();
		int cycles;
		logic [31:0] r;
		repeat (2)
			step(1'b0, 1'b1, 1'b0, 0, 1'b0);
		finish_test("reset");

		// fill thread 1 without completions
		cycles = 0;
		while (mq[0].size() <= depth - 2 && cycles < depth)
		begin
			step(1'b1, 1'b1, mq[0].size() < depth - 2, 0, 1'b0); // ends with one entry free
			cycles++;
		end
		if (mq[0].size() <= depth - 2)
		begin
			$display("timeout: thread 1 never filled up");
			timed_out = 1'b1;
			return;
		end
		step(1'b1, 1'b1, 1'b1, 0, 1'b0); // dropped while full
		finish_test("full");

		// out of order completions with in order dual commits
		dual_seen = 0;
		drain(100);
		if (timed_out)
			return;
		if (dual_seen == 0)
			report_error("no cycle committed two thread 1 entries together");
		finish_test("dual commit");

		flush_seen = 0;
		repeat (600)
		begin
			r = next_random();
			step(r[0] | r[5], r[1], r[2], int'(r[4:3]), 1'b1);
		end
		drain(200);
		if (timed_out)
			return;
		if (flush_seen == 0)
			report_error("no mispredicted branch committed during random traffic");
		finish_test("random with flush");
	endtask

	initial
	begin
		reset = 1'b1;
		is_thread1 = 1'b1;
		slot1 = '0;
		slot2 = '0;
		fu1 = '0;
		fu2 = '0;
		fu1_tag = '0;
		fu2_tag = '0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		run_tests();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* filelist.f */
hw/rob_cfg_pkg.sv
hw/rob_types_pkg.sv
hw/rob_thread_bank.sv
hw/rob_commit_arbiter.sv
hw/smt_rob.sv
test/tb_smt_rob.sv

/* run_sim.sh */
#!/bin/sh
# build and run the smt_rob testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_smt_rob -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test OK$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
